/* rtl/fdc_pkg.sv */
// ====================================================================
// fdc shared definitions
// register map, status bit positions, sequencer states and timing
// ====================================================================
`default_nettype none

package fdc_pkg;

	// host register map
	localparam logic [1:0] A_CMD_STATUS = 2'd0;
	localparam logic [1:0] A_TRACK      = 2'd1;
	localparam logic [1:0] A_SECTOR     = 2'd2;
	localparam logic [1:0] A_DATA       = 2'd3;

	typedef logic [7:0]  byte_t;
	typedef logic [19:0] img_addr_t;  // byte offset in the image, 1 MB max
	typedef logic [31:0] lba_t;
	typedef logic [10:0] buf_addr_t;  // {block, byte in block}

	localparam int BLOCK_BYTES = 512;

	// status bits, some shared between the type I and type II layouts
	localparam int ST_NOT_READY       = 7;
	localparam int ST_PROTECT         = 6;
	localparam int ST_HEAD_OR_WRFAULT = 5;
	localparam int ST_SEEK_ERR        = 4;
	localparam int ST_TRACK0_OR_LOST  = 2;
	localparam int ST_DRQ_OR_INDEX    = 1;
	localparam int ST_BUSY            = 0;

	// timing in clk_sys cycles
	localparam int TYPE1_BUSY_CYCLES  = 4000;
	localparam int BYTE_GAP_CYCLES    = 16;
	localparam int SEEK_SETTLE_CYCLES = 1023;

	typedef enum logic [3:0] {
		SEQ_IDLE,
		SEQ_SEARCH,
		SEQ_FILL_BLOCK,
		SEQ_FILL_WAIT,
		SEQ_BYTE_GAP,
		SEQ_BYTE_WAIT,
		SEQ_FLUSH_BLOCK,
		SEQ_FLUSH_WAIT,
		SEQ_BUSY_WAIT,
		SEQ_END_CMD
	} seq_state_t;

endpackage

`default_nettype wire

/* rtl/host_port.sv */
// ====================================================================
// fdc host port
// host strobe edges, track/sector/data registers and read-back mux
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module host_port (
	input  logic           clk_sys,
	input  logic           reset,
	input  logic           io_en,
	input  logic           rd,
	input  logic           wr,
	input  logic [1:0]     addr,
	input  fdc_pkg::byte_t din,
	input  fdc_pkg::byte_t status,
	input  fdc_pkg::byte_t buf_q,
	input  logic           seq_idle,
	input  logic           busy,
	output fdc_pkg::byte_t dout,
	output logic           cmd_strobe,
	output fdc_pkg::byte_t cmd_code,
	output logic           data_read_done,
	output logic           data_write_done,
	output logic           status_read_done,
	output fdc_pkg::byte_t track_reg,
	output fdc_pkg::byte_t sector_reg,
	output fdc_pkg::byte_t data_reg,
	input  logic           track_load,
	input  fdc_pkg::byte_t track_value
);

	logic       rd_s, rd_d;
	logic       wr_s, wr_d;
	logic       rd_rise, rd_fall;
	logic       wr_rise, wr_fall;
	logic [1:0] cur_addr;  // register of the access in progress

	assign rd_rise = rd_s & ~rd_d;
	assign rd_fall = ~rd_s & rd_d;
	assign wr_rise = wr_s & ~wr_d;
	assign wr_fall = ~wr_s & wr_d;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			{rd_s, rd_d, wr_s, wr_d} <= '0;
			cur_addr <= fdc_pkg::A_CMD_STATUS;
		end else begin
			rd_s <= rd & io_en;
			rd_d <= rd_s;
			wr_s <= wr & io_en;
			wr_d <= wr_s;
			if (rd_rise | wr_rise)
				cur_addr <= addr;  // trailing events use this
		end
	end

	assign cmd_strobe       = wr_rise && addr == fdc_pkg::A_CMD_STATUS;
	assign cmd_code         = din;
	assign status_read_done = rd_fall && cur_addr == fdc_pkg::A_CMD_STATUS;
	assign data_read_done   = rd_fall && cur_addr == fdc_pkg::A_DATA;
	assign data_write_done  = wr_fall && cur_addr == fdc_pkg::A_DATA;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			track_reg  <= '0;
			sector_reg <= '0;
			data_reg   <= '0;
		end else begin
			if (wr_rise) begin
				case (addr)
					fdc_pkg::A_TRACK:  if (!busy) track_reg <= din;
					fdc_pkg::A_SECTOR: if (!busy) sector_reg <= din;
					fdc_pkg::A_DATA:   data_reg <= din;
					default: ;  // command goes to the sequencer
				endcase
			end
			if (track_load)
				track_reg <= track_value;  // restore, seek, step with update
		end
	end

	always_comb begin
		case (addr)
			fdc_pkg::A_CMD_STATUS: dout = status;
			fdc_pkg::A_TRACK:      dout = track_reg;
			fdc_pkg::A_SECTOR:     dout = sector_reg;
			default:               dout = seq_idle ? data_reg : buf_q;
		endcase
	end

	// a command comes from a write with no read level beside it
	a_cmd_clean: assert property (@(posedge clk_sys) disable iff (reset)
		cmd_strobe |-> !rd_s);

endmodule

`default_nettype wire

/* rtl/disk_geometry.sv */
// ====================================================================
// fdc disk geometry
// image byte offset, sector size and block span of the selected sector
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module disk_geometry (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               img_mounted,
	input  fdc_pkg::img_addr_t img_size,
	input  logic               layout,
	input  logic [2:0]         size_code,
	input  logic               side,
	input  fdc_pkg::byte_t     head_track,
	input  fdc_pkg::byte_t     sector_reg,
	output fdc_pkg::img_addr_t sector_offset,
	output logic [10:0]        sector_bytes,
	output fdc_pkg::byte_t     spt,
	output logic [1:0]         last_block,
	output logic               sector_valid
);

	logic               old_mounted;
	logic               layout_r;
	fdc_pkg::img_addr_t disk_size;
	fdc_pkg::img_addr_t half_offset;
	fdc_pkg::byte_t     track_index;
	logic [1:0]         size_shift;  // log2 of sector size / 128
	logic [12:0]        sector_index;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_mounted <= 1'b0;
			layout_r    <= 1'b0;
			disk_size   <= '0;
		end else begin
			old_mounted <= img_mounted;
			if (old_mounted && !img_mounted) begin
				layout_r  <= layout;
				disk_size <= img_size;
			end
		end
	end

	// side-track-sector keeps side 1 in the upper half of the image
	assign half_offset = (layout_r && side) ? disk_size >> 1 : '0;
	assign track_index = {head_track[6:0], side} >> layout_r;

	always_comb begin
		case (size_code)
			3'd0:    {spt, size_shift} = {8'd26, 2'd0};
			3'd1:    {spt, size_shift} = {8'd16, 2'd1};
			3'd2:    {spt, size_shift} = {8'd9, 2'd2};
			3'd3:    {spt, size_shift} = {8'd5, 2'd3};
			default: {spt, size_shift} = {8'd10, 2'd2};  // 10 x 512
		endcase
	end

	assign sector_bytes  = 11'd128 << size_shift;
	assign sector_index  = 13'(track_index) * 13'(spt) + 13'(sector_reg) - 13'd1;
	assign sector_offset = half_offset
		+ (fdc_pkg::img_addr_t'(sector_index) << (7 + size_shift));

	// extra block when a big sector starts inside a block
	always_comb begin
		case (size_shift)
			2'd2:    last_block = (sector_offset[8:0] != '0) ? 2'd1 : 2'd0;
			2'd3:    last_block = (sector_offset[8:0] != '0) ? 2'd2 : 2'd1;
			default: last_block = 2'd0;
		endcase
	end

	assign sector_valid = sector_reg != '0 && sector_reg <= spt;

endmodule

`default_nettype wire

/* rtl/command_seq.sv */
// ====================================================================
// fdc command sequencer
// type I head moves, single sector read/write and force interrupt
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module command_seq (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               ready,
	input  logic               wp,
	input  logic               cmd_strobe,
	input  fdc_pkg::byte_t     cmd_code,
	input  logic               data_read_done,
	input  logic               data_write_done,
	input  logic               status_read_done,
	input  fdc_pkg::byte_t     track_reg,
	input  fdc_pkg::byte_t     data_reg,
	input  fdc_pkg::img_addr_t sector_offset,
	input  logic [10:0]        sector_bytes,
	input  logic [1:0]         last_block,
	input  logic               sector_valid,
	input  logic               blk_done,
	output logic               busy,
	output logic               drq,
	output logic               intrq,
	output logic [3:0]         status_flags,
	output fdc_pkg::byte_t     head_track,
	output logic               track_load,
	output fdc_pkg::byte_t     track_value,
	output logic               blk_read_req,
	output logic               blk_write_req,
	output logic [1:0]         blk_index,
	output fdc_pkg::buf_addr_t byte_addr,
	output logic               host_buf_we,
	output logic               seq_idle
);

	fdc_pkg::seq_state_t state;
	logic        type2_mode;  // status layout of the last command
	logic        head_loaded;
	logic        seek_err;
	logic        wr_fault;
	logic        step_dir;    // 1 steps out toward track 0
	logic        step_out;
	logic        is_write;
	logic        blk_outstanding;
	logic        byte_taken;
	logic [11:0] delay_cnt;
	logic [10:0] byte_cnt;    // bytes left in the sector

	assign seq_idle     = state == fdc_pkg::SEQ_IDLE;
	assign status_flags = {type2_mode, head_loaded, seek_err, wr_fault};
	assign step_out     = cmd_code[6] ? cmd_code[5] : step_dir;
	assign host_buf_we  = state == fdc_pkg::SEQ_BYTE_WAIT && is_write && data_write_done;
	assign byte_taken   = state == fdc_pkg::SEQ_BYTE_WAIT
		&& (is_write ? data_write_done : data_read_done);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state           <= fdc_pkg::SEQ_IDLE;
			{busy, drq, intrq} <= '0;
			{type2_mode, head_loaded, seek_err, wr_fault} <= '0;
			step_dir        <= 1'b0;
			head_track      <= '0;
			track_load      <= 1'b0;
			blk_read_req    <= 1'b0;
			blk_write_req   <= 1'b0;
			blk_index       <= '0;
			blk_outstanding <= 1'b0;
		end else begin
			track_load    <= 1'b0;
			blk_read_req  <= 1'b0;
			blk_write_req <= 1'b0;
			if (blk_read_req || blk_write_req)
				blk_outstanding <= 1'b1;
			else if (blk_done)
				blk_outstanding <= 1'b0;
			if (status_read_done)
				intrq <= 1'b0;

			// ====================================================================
			// transfer sequence
			case (state)
				fdc_pkg::SEQ_SEARCH: begin
					if (!ready) begin
						seek_err <= 1'b1;
						state    <= fdc_pkg::SEQ_END_CMD;
					end else if (delay_cnt != '0) begin
						delay_cnt <= delay_cnt - 1'b1;  // head settle
					end else if (!sector_valid) begin
						seek_err <= 1'b1;
						state    <= fdc_pkg::SEQ_END_CMD;
					end else begin
						blk_index <= 2'd0;
						byte_addr <= {2'b00, sector_offset[8:0]};
						byte_cnt  <= sector_bytes;
						state     <= fdc_pkg::SEQ_FILL_BLOCK;
					end
				end
				// writes fill too, so partial blocks keep their other bytes
				fdc_pkg::SEQ_FILL_BLOCK: begin
					if (!blk_outstanding) begin
						blk_read_req <= 1'b1;
						state        <= fdc_pkg::SEQ_FILL_WAIT;
					end
				end
				fdc_pkg::SEQ_FILL_WAIT: begin
					if (blk_done && blk_index == last_block) begin
						delay_cnt <= 12'(fdc_pkg::BYTE_GAP_CYCLES);
						state     <= fdc_pkg::SEQ_BYTE_GAP;
					end else if (blk_done) begin
						blk_index <= blk_index + 1'b1;
						state     <= fdc_pkg::SEQ_FILL_BLOCK;
					end
				end
				fdc_pkg::SEQ_BYTE_GAP: begin
					if (delay_cnt != '0) begin
						delay_cnt <= delay_cnt - 1'b1;
					end else begin
						drq   <= 1'b1;
						state <= fdc_pkg::SEQ_BYTE_WAIT;
					end
				end
				fdc_pkg::SEQ_BYTE_WAIT: begin
					if (byte_taken) begin
						drq <= 1'b0;
						if (byte_cnt == 11'd1) begin
							blk_index <= 2'd0;
							state     <= is_write ? fdc_pkg::SEQ_FLUSH_BLOCK
								: fdc_pkg::SEQ_END_CMD;
						end else begin
							byte_addr <= byte_addr + 1'b1;
							byte_cnt  <= byte_cnt - 1'b1;
							delay_cnt <= 12'(fdc_pkg::BYTE_GAP_CYCLES);
							state     <= fdc_pkg::SEQ_BYTE_GAP;
						end
					end
				end
				fdc_pkg::SEQ_FLUSH_BLOCK: begin
					if (!blk_outstanding) begin
						blk_write_req <= 1'b1;
						state         <= fdc_pkg::SEQ_FLUSH_WAIT;
					end
				end
				fdc_pkg::SEQ_FLUSH_WAIT: begin
					if (blk_done && blk_index == last_block) begin
						state <= fdc_pkg::SEQ_END_CMD;
					end else if (blk_done) begin
						blk_index <= blk_index + 1'b1;
						state     <= fdc_pkg::SEQ_FLUSH_BLOCK;
					end
				end
				fdc_pkg::SEQ_BUSY_WAIT: begin
					if (delay_cnt != '0)
						delay_cnt <= delay_cnt - 1'b1;
					else
						state <= fdc_pkg::SEQ_END_CMD;
				end
				fdc_pkg::SEQ_END_CMD: begin
					busy  <= 1'b0;
					drq   <= 1'b0;
					intrq <= 1'b1;
					state <= fdc_pkg::SEQ_IDLE;
				end
				default: ;
			endcase

			// ====================================================================
			// command decode lets only D through while busy
			if (cmd_strobe) begin
				intrq <= 1'b0;
				if (seq_idle || cmd_code[7:4] == 4'hD) begin
					type2_mode <= cmd_code[7];
					if (!cmd_code[7]) begin
						head_loaded <= cmd_code[3];
						busy        <= 1'b1;
						delay_cnt   <= 12'(fdc_pkg::TYPE1_BUSY_CYCLES);
						state       <= fdc_pkg::SEQ_BUSY_WAIT;
					end
					case (cmd_code[7:4])
						4'h0: begin  // restore
							head_track  <= '0;
							track_value <= '0;
							track_load  <= 1'b1;
						end
						4'h1: begin  // seek
							head_track  <= data_reg;
							track_value <= data_reg;
							track_load  <= 1'b1;
						end
						4'h8, 4'h9, 4'hA, 4'hB: begin
							busy      <= 1'b1;
							seek_err  <= 1'b0;
							wr_fault  <= 1'b0;
							is_write  <= cmd_code[5];
							delay_cnt <= 12'(fdc_pkg::SEEK_SETTLE_CYCLES);
							state     <= fdc_pkg::SEQ_SEARCH;
							if (wp && cmd_code[5]) begin  // protected disk gets no SD access
								wr_fault  <= 1'b1;
								delay_cnt <= 12'(fdc_pkg::TYPE1_BUSY_CYCLES);
								state     <= fdc_pkg::SEQ_BUSY_WAIT;
							end
						end
						4'hD: begin  // force interrupt
							type2_mode <= 1'b0;
							seek_err   <= 1'b0;
							wr_fault   <= 1'b0;
							drq        <= 1'b0;
							if (seq_idle)
								busy <= 1'b0;
							else
								state <= fdc_pkg::SEQ_END_CMD;
						end
						4'hC, 4'hE, 4'hF: begin  // address and track commands
							busy      <= 1'b1;
							seek_err  <= 1'b1;
							delay_cnt <= 12'(fdc_pkg::TYPE1_BUSY_CYCLES);
							state     <= fdc_pkg::SEQ_BUSY_WAIT;
						end
						default: begin  // step, step-in, step-out
							step_dir   <= step_out;
							head_track <= step_out ? head_track - 1'b1 : head_track + 1'b1;
							if (cmd_code[4]) begin
								track_value <= step_out ? track_reg - 1'b1 : track_reg + 1'b1;
								track_load  <= 1'b1;
							end
						end
					endcase
				end
			end
		end
	end

	a_drq_busy: assert property (@(posedge clk_sys) disable iff (reset) drq |-> busy);

	// sd_transfer only answers a block that was asked for
	a_done_requested: assert property (@(posedge clk_sys) disable iff (reset)
		blk_done |-> blk_outstanding);

endmodule

`default_nettype wire

/* rtl/sd_transfer.sv */
// ====================================================================
// fdc sd block transfer
// block read/write requests, ack edges and buffer write gating
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module sd_transfer (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               blk_read_req,
	input  logic               blk_write_req,
	input  logic [1:0]         blk_index,
	input  fdc_pkg::img_addr_t sector_offset,
	input  logic               sd_ack,
	input  logic               sd_buff_wr,
	output logic               sd_rd,
	output logic               sd_wr,
	output fdc_pkg::lba_t      sd_lba,
	output logic               blk_done,
	output logic               sd_buf_we
);

	logic old_ack;
	logic pending;  // block requested and not finished

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			{sd_rd, sd_wr} <= '0;
			old_ack  <= 1'b0;
			pending  <= 1'b0;
			blk_done <= 1'b0;
		end else begin
			old_ack  <= sd_ack;
			blk_done <= 1'b0;
			if (blk_read_req || blk_write_req)
				pending <= 1'b1;
			if (blk_read_req)
				sd_rd <= 1'b1;
			if (blk_write_req)
				sd_wr <= 1'b1;
			if (!old_ack && sd_ack)
				{sd_rd, sd_wr} <= '0;  // request taken
			if (old_ack && !sd_ack && pending) begin
				pending  <= 1'b0;
				blk_done <= 1'b1;
			end
		end
	end

	assign sd_lba = fdc_pkg::lba_t'(sector_offset / fdc_pkg::BLOCK_BYTES)
		+ fdc_pkg::lba_t'(blk_index);
	assign sd_buf_we = sd_buff_wr && sd_ack && pending;

endmodule

`default_nettype wire

/* rtl/sector_buffer.sv */
// ====================================================================
// fdc sector buffer, 2 KB dual-port byte RAM
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module sector_buffer (
	input  logic               clk_sys,
	input  fdc_pkg::buf_addr_t a_addr,  // sd side
	input  fdc_pkg::byte_t     a_data,
	input  logic               a_we,
	output fdc_pkg::byte_t     a_q,
	input  fdc_pkg::buf_addr_t b_addr,  // host side
	input  fdc_pkg::byte_t     b_data,
	input  logic               b_we,
	output fdc_pkg::byte_t     b_q
);

	fdc_pkg::byte_t ram [0:2047];

	// write-first on both ports
	always_ff @(posedge clk_sys) begin
		if (a_we)
			ram[a_addr] <= a_data;
		if (b_we)
			ram[b_addr] <= b_data;
		a_q <= a_we ? a_data : ram[a_addr];
		b_q <= b_we ? b_data : ram[b_addr];
	end

endmodule

`default_nettype wire

/* rtl/fdc_top.sv */
// ====================================================================
// fdc top level
// WD1793-style controller on a 512-byte block store
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module fdc_top (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               io_en,
	input  logic               rd,
	input  logic               wr,
	input  logic [1:0]         addr,
	input  fdc_pkg::byte_t     din,
	output fdc_pkg::byte_t     dout,
	output logic               drq,
	output logic               intrq,
	output logic               busy,
	input  logic               wp,
	input  logic               ready,
	input  logic               side,
	input  logic               layout,  // 0 track-side-sector, 1 side-track-sector
	input  logic [2:0]         size_code,
	input  logic               img_mounted,
	input  fdc_pkg::img_addr_t img_size,
	output fdc_pkg::lba_t      sd_lba,
	output logic               sd_rd,
	output logic               sd_wr,
	input  logic               sd_ack,
	input  logic [8:0]         sd_buff_addr,
	input  fdc_pkg::byte_t     sd_buff_dout,
	output fdc_pkg::byte_t     sd_buff_din,
	input  logic               sd_buff_wr
);

	fdc_pkg::byte_t     status, buf_q, cmd_code;
	fdc_pkg::byte_t     track_reg, sector_reg, data_reg;
	fdc_pkg::byte_t     track_value, head_track;
	logic               seq_idle, cmd_strobe, track_load;
	logic               data_read_done, data_write_done, status_read_done;
	fdc_pkg::img_addr_t sector_offset;
	logic [10:0]        sector_bytes;
	logic [1:0]         last_block, blk_index;
	logic               sector_valid, blk_done, sd_buf_we, host_buf_we;
	logic               blk_read_req, blk_write_req;
	logic [3:0]         status_flags;  // {type II, head loaded, seek err, wr fault}
	fdc_pkg::buf_addr_t byte_addr;

	// ====================================================================
	// status byte, type I or type II layout
	always_comb begin
		status = '0;
		status[fdc_pkg::ST_NOT_READY] = ~ready;
		status[fdc_pkg::ST_PROTECT]   = wp;
		status[fdc_pkg::ST_SEEK_ERR]  = status_flags[1] | ~ready;
		status[fdc_pkg::ST_BUSY]      = busy;
		if (status_flags[3]) begin
			status[fdc_pkg::ST_HEAD_OR_WRFAULT] = status_flags[0];
			status[fdc_pkg::ST_DRQ_OR_INDEX]    = drq;  // no lost data bit
		end else begin
			status[fdc_pkg::ST_HEAD_OR_WRFAULT] = status_flags[2];
			status[fdc_pkg::ST_TRACK0_OR_LOST]  = head_track == '0;
		end
	end

	host_port host_port_inst (
		.clk_sys, .reset, .io_en, .rd, .wr, .addr, .din, .status, .buf_q,
		.seq_idle, .busy, .dout, .cmd_strobe, .cmd_code, .data_read_done,
		.data_write_done, .status_read_done, .track_reg, .sector_reg,
		.data_reg, .track_load, .track_value
	);

	disk_geometry disk_geometry_inst (
		.clk_sys, .reset, .img_mounted, .img_size, .layout, .size_code, .side,
		.head_track, .sector_reg, .sector_offset, .sector_bytes,
		.spt(), .last_block, .sector_valid
	);

	command_seq command_seq_inst (
		.clk_sys, .reset, .ready, .wp, .cmd_strobe, .cmd_code, .data_read_done,
		.data_write_done, .status_read_done, .track_reg, .data_reg,
		.sector_offset, .sector_bytes, .last_block, .sector_valid, .blk_done,
		.busy, .drq, .intrq, .status_flags, .head_track, .track_load,
		.track_value, .blk_read_req, .blk_write_req, .blk_index, .byte_addr,
		.host_buf_we, .seq_idle
	);

	sd_transfer sd_transfer_inst (
		.clk_sys, .reset, .blk_read_req, .blk_write_req, .blk_index,
		.sector_offset, .sd_ack, .sd_buff_wr, .sd_rd, .sd_wr, .sd_lba,
		.blk_done, .sd_buf_we
	);

	sector_buffer sector_buffer_inst (
		.clk_sys,
		.a_addr({blk_index, sd_buff_addr}),
		.a_data(sd_buff_dout),
		.a_we  (sd_buf_we),
		.a_q   (sd_buff_din),
		.b_addr(byte_addr),
		.b_data(data_reg),
		.b_we  (host_buf_we),
		.b_q   (buf_q)
	);

endmodule

`default_nettype wire

/* tests/clock_gen.sv */
// ====================================================================
// testbench clock and reset
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
	parameter int PERIOD_NS    = 4,
	parameter int RESET_CYCLES = 5
) (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		reset = 1'b0;  // released just after an edge
	end

endmodule

`default_nettype wire

/* tests/tb_top.sv */
// ====================================================================
// fdc testbench
// register, head move and sector transfer tests against a block model
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_top;

	// geometry under test is size_code 1 on layout 0 and side 0
	localparam int SECTOR_SIZE = 256;
	localparam int SPT         = 16;
	localparam fdc_pkg::img_addr_t IMG_BYTES = 20'd655360;  // 80 x 2 x 16 x 256

	localparam fdc_pkg::byte_t BUSY_BIT    = 8'h01 << fdc_pkg::ST_BUSY;
	localparam fdc_pkg::byte_t DRQ_BIT     = 8'h01 << fdc_pkg::ST_DRQ_OR_INDEX;
	localparam fdc_pkg::byte_t TRACK0_BIT  = 8'h01 << fdc_pkg::ST_TRACK0_OR_LOST;
	localparam fdc_pkg::byte_t SEEK_BIT    = 8'h01 << fdc_pkg::ST_SEEK_ERR;
	localparam fdc_pkg::byte_t WRFAULT_BIT = 8'h01 << fdc_pkg::ST_HEAD_OR_WRFAULT;

	localparam int INTRQ_LIMIT = 2 * fdc_pkg::TYPE1_BUSY_CYCLES;
	localparam int DRQ_LIMIT   = fdc_pkg::SEEK_SETTLE_CYCLES + 4 * fdc_pkg::BLOCK_BYTES + 100;

	// ====================================================================
	// run length covers 5 long busy commands, 4 transfers and about 2 sectors of bytes
	localparam int LONG_CMDS  = 5;
	localparam int XFER_CMDS  = 4;
	localparam int HOST_BYTES = 2 * SECTOR_SIZE + 8;
	localparam int RUN_CYCLES = LONG_CMDS * (fdc_pkg::TYPE1_BUSY_CYCLES + 40)
		+ XFER_CMDS * (fdc_pkg::SEEK_SETTLE_CYCLES + 4 * fdc_pkg::BLOCK_BYTES)
		+ HOST_BYTES * (fdc_pkg::BYTE_GAP_CYCLES + 16);
	localparam int WATCHDOG_NS = 2 * RUN_CYCLES * 4;

	logic               clk_sys, reset;
	logic               io_en, rd, wr;
	logic [1:0]         addr;
	fdc_pkg::byte_t     din, dout;
	logic               drq, intrq, busy;
	logic               wp, ready, side, layout;
	logic [2:0]         size_code;
	logic               img_mounted;
	fdc_pkg::img_addr_t img_size;
	fdc_pkg::lba_t      sd_lba;
	logic               sd_rd, sd_wr, sd_ack, sd_buff_wr;
	logic [8:0]         sd_buff_addr;
	fdc_pkg::byte_t     sd_buff_dout, sd_buff_din;

	fdc_pkg::byte_t     shadow [0:511];  // last block written back
	fdc_pkg::lba_t      rd_lba, wr_lba;
	int                 rd_count, wr_count;
	logic [31:0]        rng_state;

	clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(5)) clock_gen_inst (
		.clk_sys(clk_sys),
		.reset  (reset)
	);

	fdc_top fdc_top_inst (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// block store content with the upper half flipped so every address differs
	function automatic fdc_pkg::byte_t sd_pattern(input fdc_pkg::lba_t lba, input int n);
		fdc_pkg::byte_t v;
		v = lba[7:0] ^ n[7:0];
		if (n[8])
			v = v ^ 8'hA5;
		return v;
	endfunction

	function automatic fdc_pkg::byte_t host_byte(input int i);
		return fdc_pkg::byte_t'(i * 37 + 11);
	endfunction

	function automatic int image_offset(input int track, input int sector);
		return ((track * 2) * SPT + sector - 1) * SECTOR_SIZE;  // side 0
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_byte(input fdc_pkg::byte_t got, input fdc_pkg::byte_t exp,
			input string what);
		if (got !== exp)
			stop_run($sformatf("ERR at %0d ns: %s is %02h, expected %02h",
				$time, what, got, exp));
	endtask

	task automatic check_lba(input fdc_pkg::lba_t got, input fdc_pkg::lba_t exp,
			input string what);
		if (got !== exp)
			stop_run($sformatf("ERR at %0d ns: %s is %08h, expected %08h",
				$time, what, got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			stop_run($sformatf("ERR at %0d ns: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	// ====================================================================
	// host bus access holds levels long enough for the strobe sync
	task automatic write_reg(input logic [1:0] a, input fdc_pkg::byte_t d);
		@(posedge clk_sys);
		#1;
		addr  = a;
		din   = d;
		io_en = 1'b1;
		wr    = 1'b1;
		repeat (3) @(posedge clk_sys);
		#1;
		wr    = 1'b0;
		io_en = 1'b0;
		repeat (3) @(posedge clk_sys);
		#1;
	endtask

	task automatic read_reg(input logic [1:0] a, output fdc_pkg::byte_t d);
		@(posedge clk_sys);
		#1;
		addr  = a;
		io_en = 1'b1;
		rd    = 1'b1;
		repeat (3) @(posedge clk_sys);
		#1;
		d     = dout;
		rd    = 1'b0;
		io_en = 1'b0;
		repeat (3) @(posedge clk_sys);
		#1;
	endtask

	task automatic wait_intrq(input string what);
		int n;
		n = 0;
		while (intrq !== 1'b1) begin
			@(posedge clk_sys);
			#1;
			n++;
			if (n > INTRQ_LIMIT)
				stop_run($sformatf("no interrupt after %s within %0d cycles", what, n));
		end
	endtask

	task automatic wait_drq(input string what);
		int n;
		n = 0;
		while (drq !== 1'b1) begin
			@(posedge clk_sys);
			#1;
			n++;
			if (n > DRQ_LIMIT)
				stop_run($sformatf("no data request during %s within %0d cycles", what, n));
		end
	endtask

	task automatic run_cmd(input fdc_pkg::byte_t cmd, input string what);
		write_reg(fdc_pkg::A_CMD_STATUS, cmd);
		wait_intrq(what);
	endtask

	task automatic mount_image();
		@(posedge clk_sys);
		#1;
		img_mounted = 1'b1;
		repeat (2) @(posedge clk_sys);
		#1;
		img_mounted = 1'b0;  // size and layout latch here
		repeat (2) @(posedge clk_sys);
		#1;
	endtask

	// ====================================================================
	// directed tests
	task automatic reset_values();
		fdc_pkg::byte_t st;
		check_flag(busy, 1'b0, "busy after reset");
		check_flag(drq, 1'b0, "drq after reset");
		check_flag(intrq, 1'b0, "intrq after reset");
		check_flag(sd_rd | sd_wr, 1'b0, "sd request after reset");
		read_reg(fdc_pkg::A_CMD_STATUS, st);
		check_byte(st & (BUSY_BIT | DRQ_BIT), 8'h00, "status busy/drq after reset");
	endtask

	task automatic head_moves();
		fdc_pkg::byte_t v;
		write_reg(fdc_pkg::A_TRACK, 8'h27);
		run_cmd(8'h00, "restore");
		read_reg(fdc_pkg::A_TRACK, v);
		check_byte(v, 8'd0, "track after restore");
		read_reg(fdc_pkg::A_CMD_STATUS, v);
		check_byte(v & TRACK0_BIT, TRACK0_BIT, "track 0 bit after restore");
		run_cmd(8'h50, "step-in");  // with track update
		read_reg(fdc_pkg::A_TRACK, v);
		check_byte(v, 8'd1, "track after step-in");
		read_reg(fdc_pkg::A_CMD_STATUS, v);
		check_byte(v & TRACK0_BIT, 8'h00, "track 0 bit after step-in");
		write_reg(fdc_pkg::A_DATA, 8'd5);
		run_cmd(8'h10, "seek");
		run_cmd(8'h70, "step-out");
		read_reg(fdc_pkg::A_TRACK, v);
		check_byte(v, 8'd4, "track after seek and step-out");
	endtask

	// head is left on track 4 by head_moves
	task automatic sector_read(input int sector);
		fdc_pkg::byte_t v;
		fdc_pkg::lba_t  lba;
		int             offset;
		int             first;
		offset = image_offset(4, sector);
		lba    = fdc_pkg::lba_t'(offset / fdc_pkg::BLOCK_BYTES);
		first  = offset % fdc_pkg::BLOCK_BYTES;
		write_reg(fdc_pkg::A_SECTOR, fdc_pkg::byte_t'(sector));
		write_reg(fdc_pkg::A_CMD_STATUS, 8'h80);
		for (int i = 0; i < SECTOR_SIZE; i++) begin
			wait_drq("sector read");
			read_reg(fdc_pkg::A_DATA, v);
			check_byte(v, sd_pattern(lba, first + i), "read sector data");
		end
		check_lba(rd_lba, lba, "read sector lba");
		wait_intrq("sector read");
		read_reg(fdc_pkg::A_CMD_STATUS, v);
		check_byte(v & (BUSY_BIT | SEEK_BIT), 8'h00, "status after read");
	endtask

	task automatic sector_write(input int sector);
		fdc_pkg::byte_t v;
		fdc_pkg::byte_t exp;
		fdc_pkg::lba_t  lba;
		int             offset;
		int             first;
		int             writes;
		offset = image_offset(4, sector);
		lba    = fdc_pkg::lba_t'(offset / fdc_pkg::BLOCK_BYTES);
		first  = offset % fdc_pkg::BLOCK_BYTES;
		writes = wr_count;
		write_reg(fdc_pkg::A_SECTOR, fdc_pkg::byte_t'(sector));
		write_reg(fdc_pkg::A_CMD_STATUS, 8'hA0);
		for (int i = 0; i < SECTOR_SIZE; i++) begin
			wait_drq("sector write");
			write_reg(fdc_pkg::A_DATA, host_byte(i));
		end
		wait_intrq("sector write");
		check_flag(wr_count == writes + 1, 1'b1, "one block written back");
		check_lba(wr_lba, lba, "write sector lba");
		for (int n = 0; n < fdc_pkg::BLOCK_BYTES; n++) begin
			if (n >= first && n < first + SECTOR_SIZE)
				exp = host_byte(n - first);
			else
				exp = sd_pattern(lba, n);  // kept from the fill
			check_byte(shadow[n], exp, "written block");
		end
		read_reg(fdc_pkg::A_CMD_STATUS, v);
		check_byte(v & (BUSY_BIT | WRFAULT_BIT), 8'h00, "status after write");
	endtask

	task automatic error_cases();
		fdc_pkg::byte_t v;
		int             writes;
		int             reads;
		writes = wr_count;
		@(posedge clk_sys);
		#1;
		wp = 1'b1;
		run_cmd(8'hA0, "protected write");
		read_reg(fdc_pkg::A_CMD_STATUS, v);
		check_byte(v & WRFAULT_BIT, WRFAULT_BIT, "write fault bit");
		check_flag(wr_count == writes, 1'b1, "no block write when protected");
		wp = 1'b0;
		reads = rd_count;
		write_reg(fdc_pkg::A_SECTOR, 8'd17);
		run_cmd(8'h80, "read of sector 17");
		read_reg(fdc_pkg::A_CMD_STATUS, v);
		check_byte(v & SEEK_BIT, SEEK_BIT, "seek error bit for sector 17");
		check_flag(rd_count == reads, 1'b1, "no block read for sector 17");
	endtask

	// the aborted read never finishes, so only D can raise intrq here
	task automatic force_abort();
		fdc_pkg::byte_t v;
		write_reg(fdc_pkg::A_SECTOR, 8'd3);
		write_reg(fdc_pkg::A_CMD_STATUS, 8'h80);
		wait_drq("read before abort");
		read_reg(fdc_pkg::A_DATA, v);
		wait_drq("read before abort");
		run_cmd(8'hD0, "force interrupt");
		check_flag(busy, 1'b0, "busy after force interrupt");
		check_flag(drq, 1'b0, "drq after force interrupt");
		read_reg(fdc_pkg::A_CMD_STATUS, v);
		check_byte(v & BUSY_BIT, 8'h00, "status busy after force interrupt");
	endtask

	// ====================================================================
	// block store model serving one 512-byte block per request
	task automatic serve_read();
		rd_lba = sd_lba;
		rd_count++;
		sd_ack = 1'b1;
		for (int n = 0; n < fdc_pkg::BLOCK_BYTES; n++) begin
			sd_buff_addr = 9'(n);
			sd_buff_dout = sd_pattern(rd_lba, n);
			sd_buff_wr   = 1'b1;
			@(posedge clk_sys);
			#1;
		end
		sd_buff_wr = 1'b0;
		sd_ack     = 1'b0;
	endtask

	task automatic serve_write();
		wr_lba = sd_lba;
		wr_count++;
		sd_ack = 1'b1;
		for (int n = 0; n < fdc_pkg::BLOCK_BYTES; n++) begin
			sd_buff_addr = 9'(n);
			@(posedge clk_sys);
			#1;
			shadow[n] = sd_buff_din;  // one cycle read latency
		end
		sd_ack = 1'b0;
	endtask

	initial begin : block_store
		sd_ack       = 1'b0;
		sd_buff_wr   = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		rd_count     = 0;
		wr_count     = 0;
		rd_lba       = '0;
		wr_lba       = '0;
		forever begin
			@(posedge clk_sys);
			#1;
			if (sd_rd)
				serve_read();
			else if (sd_wr)
				serve_write();
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		stop_run($sformatf("watchdog expired after %0d ns", WATCHDOG_NS));
	end

	initial begin
		io_en       = 1'b0;
		rd          = 1'b0;
		wr          = 1'b0;
		addr        = fdc_pkg::A_CMD_STATUS;
		din         = '0;
		wp          = 1'b0;
		ready       = 1'b1;
		side        = 1'b0;
		layout      = 1'b0;
		size_code   = 3'd1;  // 16 x 256
		img_mounted = 1'b0;
		img_size    = IMG_BYTES;
		rng_state   = 32'd92;
		wait (reset === 1'b0);
		@(posedge clk_sys);
		#1;
		reset_values();
		mount_image();
		head_moves();
		rng_state = xorshift(rng_state);
		sector_read(int'(rng_state[3:0]) + 1);
		rng_state = xorshift(rng_state);
		sector_write(int'(rng_state[3:0]) + 1);
		error_cases();
		force_abort();
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
rtl/fdc_pkg.sv
rtl/host_port.sv
rtl/disk_geometry.sv
rtl/command_seq.sv
rtl/sd_transfer.sv
rtl/sector_buffer.sv
rtl/fdc_top.sv
tests/clock_gen.sv
tests/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the fdc testbench with Verilator and run it
# exit status is nonzero when the build fails or a check stops the run

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_top -o tb_sim -f tb.f \
	&& ./obj_dir/tb_sim \
	|| exit 1
